// File: tmr_tests.txt
// instr_mask_rd_result_we_faults(a,b,c,sys)_hazard
// hazard is the expected stall count; nonzero vectors issue right after the one before
00500093_0_01_00000005_1_0_0
00C00113_0_02_0000000C_1_0_0
FFD00193_0_03_FFFFFFFD_1_0_0
// Register-register ops on x1=5, x2=12, x3=-3
00208233_0_04_00000011_1_0_0
402082B3_0_05_FFFFFFF9_1_0_0
0020F333_0_06_00000004_1_0_0
0020E3B3_0_07_0000000D_1_0_0
0020C433_0_08_00000009_1_0_0
001194B3_0_09_FFFFFFA0_1_0_0
0011D533_0_0A_07FFFFFF_1_0_0
0011A5B3_0_0B_00000001_1_0_0
0030A633_0_0C_00000000_1_0_0
// Immediate ops with negative immediates
FF01F693_0_0D_FFFFFFF0_1_0_0
F000E713_0_0E_FFFFFF05_1_0_0
FFF14793_0_0F_FFFFFFF3_1_0_0
FF608813_0_10_FFFFFFFB_1_0_0
// Dependence chain
00108893_0_11_00000006_1_0_0
01188933_0_12_0000000C_1_0_1
401909B3_0_13_00000007_1_0_1
// Single upsets on a, b, c, then all three
00208A33_1_14_00000011_1_8_0
00208AB3_2_15_00000011_1_4_0
0020CB33_4_16_00000009_1_2_0
0020EBB3_7_17_0000000D_1_1_0
// Unsupported opcode, then x0 write and reads
123450B7_1_00_00000000_0_0_0
00508013_0_00_0000000A_1_0_0
00000C33_0_18_00000000_1_0_0
00008C93_0_19_00000005_1_0_0

// File: sources.f
tmr_pkg.sv
exec_if.sv
reg_bank.sv
decoder.sv
execute_unit.sv
majority_voter.sv
tmr_core.sv
tb_tmr_core.sv

// File: tb_tmr_core.sv
`timescale 1ns/1ps

module tb_tmr_core;
    import tmr_pkg::*;

    localparam int max_vecs = 64;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    word_t       instruction_i;
    upset_mask_t fault_inject_i;
    logic        hazard_o;
    logic        write_enable_o;
    reg_addr_t   rd_o;
    word_t       result_voted_o;
    word_t       result_a_o;
    word_t       result_b_o;
    word_t       result_c_o;
    logic        fault_a_o;
    logic        fault_b_o;
    logic        fault_c_o;
    logic        system_fault_o;

    // instr[87:56] mask[55:52] rd[51:44] result[43:12] we[11:8] faults[7:4] hazard[3:0]
    logic [87:0] vectors [0:max_vecs-1];
    int          vec_errors [0:max_vecs-1];
    int          num_vecs;
    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int          cycle_limit;

    // Vector whose outputs are still on the way
    logic        pend_valid;
    int          pend_idx;
    int          neg_since_accept;

    tmr_core i_tmr_core (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .instruction_i  (instruction_i),
        .fault_inject_i (fault_inject_i),
        .hazard_o       (hazard_o),
        .write_enable_o (write_enable_o),
        .rd_o           (rd_o),
        .result_voted_o (result_voted_o),
        .result_a_o     (result_a_o),
        .result_b_o     (result_b_o),
        .result_c_o     (result_c_o),
        .fault_a_o      (fault_a_o),
        .fault_b_o      (fault_b_o),
        .fault_c_o      (fault_c_o),
        .system_fault_o (system_fault_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output check, one vector
    ////////////////////////////////////////////////////////////

    task automatic check_vector(input int idx);
        logic [87:0] v;
        word_t       exp_result;
        word_t       exp_a;
        word_t       exp_b;
        word_t       exp_c;
        reg_addr_t   exp_rd;
        logic [2:0]  mask;
        logic        exp_we;
        logic [3:0]  exp_faults;
        logic [3:0]  got_faults;
        v          = vectors[idx];
        mask       = v[54:52];
        exp_rd     = v[48:44];
        exp_result = v[43:12];
        exp_we     = v[8];
        exp_faults = v[7:4];
        got_faults = {fault_a_o, fault_b_o, fault_c_o, system_fault_o};
        // Replica k flips its own bit k
        exp_a      = exp_result;
        exp_b      = exp_result;
        exp_c      = exp_result;
        exp_a[0]   = exp_a[0] ^ mask[0];
        exp_b[1]   = exp_b[1] ^ mask[1];
        exp_c[2]   = exp_c[2] ^ mask[2];

        if (write_enable_o !== exp_we) begin
            $display("[FAIL] %t: vector %0d write_enable_o is %b, expected %b",
                     $time, idx, write_enable_o, exp_we);
            vec_errors[idx]++;
        end
        if (exp_we && rd_o !== exp_rd) begin
            $display("[FAIL] %t: vector %0d rd_o is %0d, expected %0d",
                     $time, idx, rd_o, exp_rd);
            vec_errors[idx]++;
        end
        if (exp_we && result_voted_o !== exp_result) begin
            $display("[FAIL] %t: vector %0d result_voted_o is %h, expected %h",
                     $time, idx, result_voted_o, exp_result);
            vec_errors[idx]++;
        end
        if (exp_we && result_a_o !== exp_a) begin
            $display("[FAIL] %t: vector %0d result_a_o is %h, expected %h",
                     $time, idx, result_a_o, exp_a);
            vec_errors[idx]++;
        end
        if (exp_we && result_b_o !== exp_b) begin
            $display("[FAIL] %t: vector %0d result_b_o is %h, expected %h",
                     $time, idx, result_b_o, exp_b);
            vec_errors[idx]++;
        end
        if (exp_we && result_c_o !== exp_c) begin
            $display("[FAIL] %t: vector %0d result_c_o is %h, expected %h",
                     $time, idx, result_c_o, exp_c);
            vec_errors[idx]++;
        end
        if (got_faults !== exp_faults) begin
            $display("[FAIL] %t: vector %0d faults a,b,c,sys are %b, expected %b",
                     $time, idx, got_faults, exp_faults);
            vec_errors[idx]++;
        end

        if (vec_errors[idx] == 0) begin
            pass_count++;
            $display("vector %0d (%h) ok", idx, v[87:56]);
        end else begin
            fail_count++;
            $display("vector %0d (%h) had %0d mismatches", idx, v[87:56], vec_errors[idx]);
        end
    endtask

    // Step to the falling edge and check the pending vector
    task automatic step_negedge();
        @(negedge clk_i);
        neg_since_accept++;
        // The stall or hazard bubble ahead of the pending vector must not write
        if (pend_valid && neg_since_accept == 1 && write_enable_o !== 1'b0) begin
            $display("[FAIL] %t: vector %0d write_enable_o high for the bubble ahead of it",
                     $time, pend_idx);
            vec_errors[pend_idx]++;
        end
        if (pend_valid && neg_since_accept == 2) begin
            check_vector(pend_idx);
            pend_valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [87:0] vec;
        int          exp_haz;
        int          haz_cycles;

        $timeformat(-9, 0, " ns", 0);
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        stall_i          = 1'b0;
        instruction_i    = '0;
        fault_inject_i   = '0;
        pass_count       = 0;
        fail_count       = 0;
        cycle_count      = 0;
        cycle_limit      = 0;
        pend_valid       = 1'b0;
        pend_idx         = 0;
        neg_since_accept = 0;

        $readmemh("tmr_tests.txt", vectors);
        num_vecs = 0;
        while (num_vecs < max_vecs && !$isunknown(vectors[num_vecs])) begin
            vec_errors[num_vecs] = 0;
            num_vecs++;
        end
        cycle_limit = 4 * num_vecs + 50;
        if (num_vecs == 0) begin
            $display("No test vectors could be read from tmr_tests.txt");
            fail_count++;
        end

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;

        // State right after reset
        @(negedge clk_i);
        if (write_enable_o !== 1'b0 || hazard_o !== 1'b0 ||
            {fault_a_o, fault_b_o, fault_c_o, system_fault_o} !== 4'b0000 ||
            result_a_o !== '0 || result_b_o !== '0 || result_c_o !== '0) begin
            $display("[FAIL] %t: outputs not cleared after reset", $time);
            fail_count++;
        end else begin
            pass_count++;
            $display("reset state ok");
        end
        @(posedge clk_i);

        for (int i = 0; i < num_vecs; i++) begin
            vec     = vectors[i];
            exp_haz = vec[3:0];
            // Dependent vectors follow at once and the rest after a stall cycle
            if (exp_haz == 0) begin
                stall_i <= 1'b1;
                step_negedge();
                @(posedge clk_i);
            end
            stall_i        <= 1'b0;
            instruction_i  <= vec[87:56];
            fault_inject_i <= vec[54:52];
            haz_cycles = 0;
            step_negedge();
            while (hazard_o) begin
                haz_cycles++;
                @(posedge clk_i);
                step_negedge();
            end
            if (haz_cycles != exp_haz) begin
                $display("[FAIL] %t: vector %0d held by hazard_o for %0d cycles, expected %0d",
                         $time, i, haz_cycles, exp_haz);
                vec_errors[i]++;
            end
            // Accepted on this edge
            @(posedge clk_i);
            pend_valid       = 1'b1;
            pend_idx         = i;
            neg_since_accept = 0;
        end

        // Let the last vector reach the outputs
        stall_i <= 1'b1;
        step_negedge();
        @(posedge clk_i);
        step_negedge();

        $display("Summary: %0d checks clean, %0d with mismatches", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tmr_core.sv
`timescale 1ns/1ps

module tmr_core (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  tmr_pkg::word_t       instruction_i,
    input  tmr_pkg::upset_mask_t fault_inject_i,
    output logic                 hazard_o,
    output logic                 write_enable_o,
    output tmr_pkg::reg_addr_t   rd_o,
    output tmr_pkg::word_t       result_voted_o,
    output tmr_pkg::word_t       result_a_o,
    output tmr_pkg::word_t       result_b_o,
    output tmr_pkg::word_t       result_c_o,
    output logic                 fault_a_o,
    output logic                 fault_b_o,
    output logic                 fault_c_o,
    output logic                 system_fault_o
);
    import tmr_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      we_a;
    logic      we_b;
    logic      we_c;
    reg_addr_t rd_a;
    reg_addr_t rd_b;
    reg_addr_t rd_c;

    exec_if exec_bus ();

    ////////////////////////////////////////////////////////////
    // Decode and register bank
    ////////////////////////////////////////////////////////////

    decoder i_decoder (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .upset_i       (fault_inject_i),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .hazard_o      (hazard_o),
        .issue         (exec_bus.issue)
    );

    // Written back from the voted result
    reg_bank i_reg_bank (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (write_enable_o),
        .rd_i       (rd_o),
        .wdata_i    (result_voted_o)
    );

    ////////////////////////////////////////////////////////////
    // Execute replicas and voter
    ////////////////////////////////////////////////////////////

    execute_unit #(.REPLICA_ID(0)) i_execute_a (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .exec     (exec_bus.exec),
        .result_o (result_a_o),
        .we_o     (we_a),
        .rd_o     (rd_a)
    );

    execute_unit #(.REPLICA_ID(1)) i_execute_b (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .exec     (exec_bus.exec),
        .result_o (result_b_o),
        .we_o     (we_b),
        .rd_o     (rd_b)
    );

    execute_unit #(.REPLICA_ID(2)) i_execute_c (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .exec     (exec_bus.exec),
        .result_o (result_c_o),
        .we_o     (we_c),
        .rd_o     (rd_c)
    );

    majority_voter i_majority_voter (
        .result_a_i     (result_a_o),
        .result_b_i     (result_b_o),
        .result_c_i     (result_c_o),
        .we_a_i         (we_a),
        .we_b_i         (we_b),
        .we_c_i         (we_c),
        .rd_a_i         (rd_a),
        .rd_b_i         (rd_b),
        .rd_c_i         (rd_c),
        .result_o       (result_voted_o),
        .we_o           (write_enable_o),
        .rd_o           (rd_o),
        .fault_a_o      (fault_a_o),
        .fault_b_o      (fault_b_o),
        .fault_c_o      (fault_c_o),
        .system_fault_o (system_fault_o)
    );

endmodule

// File: majority_voter.sv
`timescale 1ns/1ps

module majority_voter (
    input  tmr_pkg::word_t     result_a_i,
    input  tmr_pkg::word_t     result_b_i,
    input  tmr_pkg::word_t     result_c_i,
    input  logic               we_a_i,
    input  logic               we_b_i,
    input  logic               we_c_i,
    input  tmr_pkg::reg_addr_t rd_a_i,
    input  tmr_pkg::reg_addr_t rd_b_i,
    input  tmr_pkg::reg_addr_t rd_c_i,
    output tmr_pkg::word_t     result_o,
    output logic               we_o,
    output tmr_pkg::reg_addr_t rd_o,
    output logic               fault_a_o,
    output logic               fault_b_o,
    output logic               fault_c_o,
    output logic               system_fault_o
);
    import tmr_pkg::*;

    // Write enable, rd and result voted as one word
    localparam int pack_w = 1 + $bits(reg_addr_t) + xlen;

    logic [pack_w-1:0] pack_a;
    logic [pack_w-1:0] pack_b;
    logic [pack_w-1:0] pack_c;
    logic              agree_ab;
    logic              agree_ac;
    logic              agree_bc;

    function automatic logic [pack_w-1:0] vote(input logic [pack_w-1:0] a,
                                               input logic [pack_w-1:0] b,
                                               input logic [pack_w-1:0] c);
        return (a & b) | (a & c) | (b & c);
    endfunction

    assign pack_a = {we_a_i, rd_a_i, result_a_i};
    assign pack_b = {we_b_i, rd_b_i, result_b_i};
    assign pack_c = {we_c_i, rd_c_i, result_c_i};

    assign {we_o, rd_o, result_o} = vote(pack_a, pack_b, pack_c);

    assign agree_ab = (pack_a == pack_b);
    assign agree_ac = (pack_a == pack_c);
    assign agree_bc = (pack_b == pack_c);

    // Odd one out against an agreeing pair
    assign fault_a_o      = agree_bc && !agree_ab;
    assign fault_b_o      = agree_ac && !agree_ab;
    assign fault_c_o      = agree_ab && !agree_ac;
    assign system_fault_o = !agree_ab && !agree_ac && !agree_bc;

endmodule

// File: execute_unit.sv
`timescale 1ns/1ps

module execute_unit #(
    parameter int REPLICA_ID = 0
) (
    input  logic               clk_i,
    input  logic               rst_i,
    exec_if.exec               exec,
    output tmr_pkg::word_t     result_o,
    output logic               we_o,
    output tmr_pkg::reg_addr_t rd_o
);
    import tmr_pkg::*;

    word_t              alu_result;
    word_t              flip_mask;
    logic [shamt_w-1:0] shamt;

    assign shamt = exec.operand_b[shamt_w-1:0];

    always_comb begin
        case (exec.op)
            ALU_ADD: alu_result = exec.operand_a + exec.operand_b;
            ALU_SUB: alu_result = exec.operand_a - exec.operand_b;
            ALU_AND: alu_result = exec.operand_a & exec.operand_b;
            ALU_OR:  alu_result = exec.operand_a | exec.operand_b;
            ALU_XOR: alu_result = exec.operand_a ^ exec.operand_b;
            ALU_SLL: alu_result = exec.operand_a << shamt;
            ALU_SRL: alu_result = exec.operand_a >> shamt;
            ALU_SLT: alu_result = word_t'($signed(exec.operand_a) < $signed(exec.operand_b));
            default: alu_result = '0;
        endcase
    end

    // Modelled single-event upset on this replica's own bit
    always_comb begin
        flip_mask             = '0;
        flip_mask[REPLICA_ID] = exec.upset[REPLICA_ID];
    end

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
            we_o     <= 1'b0;
            rd_o     <= '0;
        end else begin
            result_o <= alu_result ^ flip_mask;
            we_o     <= exec.valid;
            rd_o     <= exec.rd;
        end
    end

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  tmr_pkg::word_t       instruction_i,
    input  tmr_pkg::upset_mask_t upset_i,
    output tmr_pkg::reg_addr_t   rs1_o,
    output tmr_pkg::reg_addr_t   rs2_o,
    input  tmr_pkg::word_t       rs1_data_i,
    input  tmr_pkg::word_t       rs2_data_i,
    output logic                 hazard_o,
    exec_if.issue                issue
);
    import tmr_pkg::*;

    logic [OPC_W-1:0] opcode;
    logic [2:0]       funct3;
    logic [F7_W-1:0]  funct7;
    reg_addr_t        rd;
    word_t            imm;

    alu_op_e          dec_op;
    logic             supported;
    logic             use_imm;
    logic             reads_rs1;
    logic             reads_rs2;
    logic             accept;

    ////////////////////////////////////////////////////////////
    // Field split
    ////////////////////////////////////////////////////////////

    assign opcode = instruction_i[OPC_LSB +: OPC_W];
    assign funct3 = instruction_i[F3_LSB +: 3];
    assign funct7 = instruction_i[F7_LSB +: F7_W];
    assign rd     = instruction_i[RD_LSB +: 5];
    assign rs1_o  = instruction_i[RS1_LSB +: 5];
    assign rs2_o  = instruction_i[RS2_LSB +: 5];

    // I-type immediate, sign extended
    assign imm = {{(xlen-IMM_W){instruction_i[IMM_LSB+IMM_W-1]}},
                  instruction_i[IMM_LSB +: IMM_W]};

    ////////////////////////////////////////////////////////////
    // Operation decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        dec_op    = ALU_ADD;
        supported = 1'b1;
        use_imm   = 1'b0;

        case (opcode)
            OPC_OP: begin
                case (funct3)
                    F3_ADD_SUB: dec_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_op = ALU_SLL;
                    F3_SLT:     dec_op = ALU_SLT;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_SRL:     dec_op = ALU_SRL;
                    F3_OR:      dec_op = ALU_OR;
                    F3_AND:     dec_op = ALU_AND;
                    default:    supported = 1'b0;
                endcase
                // Only SUB may use the alternate funct7
                if (!(funct7 == F7_BASE || (funct7 == F7_ALT && funct3 == F3_ADD_SUB))) begin
                    supported = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec_op = ALU_ADD;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_OR:      dec_op = ALU_OR;
                    F3_AND:     dec_op = ALU_AND;
                    default:    supported = 1'b0;
                endcase
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // Unsupported words read nothing, so they never stall
        reads_rs1 = supported;
        reads_rs2 = supported && !use_imm;
    end

    ////////////////////////////////////////////////////////////
    // Hazard against the instruction now in execute
    ////////////////////////////////////////////////////////////

    assign hazard_o = issue.valid && issue.rd != '0 &&
                      ((reads_rs1 && rs1_o == issue.rd) ||
                       (reads_rs2 && rs2_o == issue.rd));

    assign accept = !stall_i && !hazard_o;

    // Issue register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue.valid     <= 1'b0;
            issue.op        <= ALU_ADD;
            issue.operand_a <= '0;
            issue.operand_b <= '0;
            issue.rd        <= '0;
            issue.upset     <= '0;
        end else if (accept) begin
            issue.valid     <= supported;
            issue.op        <= dec_op;
            issue.operand_a <= rs1_data_i;
            issue.operand_b <= use_imm ? imm : rs2_data_i;
            issue.rd        <= rd;
            issue.upset     <= supported ? upset_i : '0;
        end else begin
            // Bubble
            issue.valid <= 1'b0;
            issue.upset <= '0;
        end
    end

endmodule

// File: reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
    input  logic               clk_i,
    input  logic               rst_i,
    input  tmr_pkg::reg_addr_t rs1_i,
    input  tmr_pkg::reg_addr_t rs2_i,
    output tmr_pkg::word_t     rs1_data_o,
    output tmr_pkg::word_t     rs2_data_o,
    input  logic               we_i,
    input  tmr_pkg::reg_addr_t rd_i,
    input  tmr_pkg::word_t     wdata_i
);
    import tmr_pkg::*;

    word_t regs [num_regs];

    // x0 is hardwired, a same-cycle write is forwarded
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (we_i && addr == rd_i) begin
            value = wdata_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

// File: exec_if.sv
`timescale 1ns/1ps

interface exec_if;
    import tmr_pkg::*;

    logic        valid;
    alu_op_e     op;
    word_t       operand_a;
    word_t       operand_b;
    reg_addr_t   rd;
    upset_mask_t upset;

    // Decoder drives one instruction per cycle
    modport issue (
        output valid,
        output op,
        output operand_a,
        output operand_b,
        output rd,
        output upset
    );

    // Replicas take every cycle, no handshake
    modport exec (
        input valid,
        input op,
        input operand_a,
        input operand_b,
        input rd,
        input upset
    );

endinterface

// File: tmr_pkg.sv
package tmr_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////////////////

    localparam int xlen         = 32;
    localparam int num_replicas = 3;
    localparam int num_regs     = 32;

    // Shift amount taken from the low bits of operand b
    localparam int shamt_w      = $clog2(xlen);

    typedef logic [xlen-1:0]         word_t;
    typedef logic [4:0]              reg_addr_t;
    typedef logic [num_replicas-1:0] upset_mask_t;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    localparam int OPC_LSB = 0;
    localparam int OPC_W   = 7;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;
    localparam int F7_W    = 7;
    localparam int IMM_LSB = 20;
    localparam int IMM_W   = 12;

    ////////////////////////////////////////////////////////////
    // Opcodes and function codes
    ////////////////////////////////////////////////////////////

    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 for the base ops and for SUB
    localparam logic [F7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [F7_W-1:0] F7_ALT  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

endpackage
